// File: design/bus_pkg.sv
package bus_pkg;

    // bus address and data words
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;

    // load/store size code in the encoding the cpu puts on the bus
    // bit 2 marks the unsigned loads
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_t;

    // decoded bus target
    typedef enum logic [2:0] {
        TGT_NONE     = 3'd0,
        TGT_RAM      = 3'd1,
        TGT_KEY      = 3'd2,
        TGT_UART     = 3'd3,
        TGT_MTIME    = 3'd4,
        TGT_MTIMECMP = 3'd5
    } target_t;

    // address map
    // ram window size comes from the RAM_WORDS parameter
    localparam addr_t RAM_BASE      = 64'h0000_0000_0000_1000;
    localparam addr_t KEY_ADDR      = 64'h0000_0000_0000_8000;
    localparam addr_t UART_ADDR     = 64'h0000_0000_0000_8008;
    // clint style timer registers
    localparam addr_t MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
    localparam addr_t MTIME_ADDR    = 64'h0000_0000_0200_bff8;

    // request as held by the cpu side
    typedef struct packed {
        addr_t    addr;
        ls_type_t ls_type;
        data_t    wdata;
    } bus_req_t;

    // one access beat from decode to access
    typedef struct packed {
        logic        valid;
        logic        is_write;
        target_t     target;
        logic [31:0] word_index;
        logic [1:0]  byte_offset;
        ls_type_t    ls_type;
        logic        beat;
        logic        last;
        logic [31:0] wdata;
    } access_t;

    // one response beat from access to align
    typedef struct packed {
        logic       valid;
        logic       is_write;
        logic       last;
        logic       beat;
        logic [1:0] byte_offset;
        ls_type_t   ls_type;
        data_t      rdata;
    } resp_t;

endpackage

// File: design/ram_bank.sv
`timescale 1ns/1ps

module ram_bank import bus_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  access_t access,
    output resp_t   ram_resp
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0] mem [0:RAM_WORDS-1];
    logic [31:0] rd_word;
    logic [AW-1:0] idx;
    logic        hit;
    logic [3:0]  lane_en;
    logic [31:0] lane_data;
    resp_t       meta_q;

    assign hit = access.valid && (access.target == TGT_RAM);
    assign idx = access.word_index[AW-1:0];

    // byte lanes from size and offset
    // store data replicated so every lane sees its byte
    always_comb begin
        case (access.ls_type)
            LS_B, LS_BU: begin
                lane_en   = 4'b0001 << access.byte_offset;
                lane_data = {4{access.wdata[7:0]}};
            end
            LS_H, LS_HU: begin
                lane_en   = 4'b0011 << access.byte_offset;
                lane_data = {2{access.wdata[15:0]}};
            end
            default: begin
                // word or one half of a double
                lane_en   = 4'b1111;
                lane_data = access.wdata;
            end
        endcase
    end

    // store lands one edge after the beat and the read is registered too
    always_ff @(posedge CLOCK_50) begin
        if (hit && access.is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    mem[idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
        rd_word <= mem[idx];
    end

    // response tag follows the beat
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            meta_q <= '0;
        end else begin
            meta_q <= '0;
            if (hit) begin
                meta_q.valid       <= 1'b1;
                meta_q.is_write    <= access.is_write;
                meta_q.last        <= access.last;
                meta_q.beat        <= access.beat;
                meta_q.byte_offset <= access.byte_offset;
                meta_q.ls_type     <= access.ls_type;
            end
        end
    end

    // whole word zero extended with alignment left downstream
    always_comb begin
        ram_resp       = meta_q;
        ram_resp.rdata = meta_q.valid ? {32'd0, rd_word} : '0;
    end

endmodule

// File: design/periph_regs.sv
`timescale 1ns/1ps

module periph_regs import bus_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  access_t    access,
    input  logic [7:0] ascii,
    input  logic       key_pressed,
    input  data_t      mtime,
    input  logic       interrupt_ack,
    output resp_t      reg_resp,
    output logic       uart_write,
    output logic [7:0] uart_data,
    output logic [3:0] interrupt_vector
);

    data_t mtimecmp;
    data_t rd_val;
    logic  hit;

    // everything except ram including unmapped space
    assign hit = access.valid && (access.target != TGT_RAM);

    // register read mux
    always_comb begin
        case (access.target)
            TGT_KEY:      rd_val = {56'd0, ascii};
            TGT_MTIME:    rd_val = mtime;
            TGT_MTIMECMP: rd_val = mtimecmp;
            default:      rd_val = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            reg_resp   <= '0;
            uart_write <= 1'b0;
            uart_data  <= '0;
            mtimecmp   <= '0;
        end else begin
            reg_resp   <= '0;
            uart_write <= 1'b0;
            if (hit) begin
                reg_resp.valid       <= 1'b1;
                reg_resp.is_write    <= access.is_write;
                reg_resp.last        <= access.last;
                reg_resp.beat        <= access.beat;
                reg_resp.byte_offset <= access.byte_offset;
                reg_resp.ls_type     <= access.ls_type;
                // beat 1 of ld returns the upper half in the low word
                if (!access.is_write) begin
                    reg_resp.rdata <= access.beat ? {32'd0, rd_val[63:32]} : rd_val;
                end
            end
            // one pulse per store even for sd
            if (hit && access.is_write && access.target == TGT_UART && !access.beat) begin
                uart_write <= 1'b1;
                uart_data  <= access.wdata[7:0];
            end
            // beat picks the half
            if (hit && access.is_write && access.target == TGT_MTIMECMP) begin
                if (access.beat) begin
                    mtimecmp[63:32] <= access.wdata;
                end else begin
                    mtimecmp[31:0] <= access.wdata;
                end
            end
        end
    end

    // keyboard interrupt level
    // ack clears and wins over a key on the same edge
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= '0;
        end else if (interrupt_vector != 4'd0 && interrupt_ack) begin
            interrupt_vector <= 4'd0;
        end else if (key_pressed && ascii != 8'd0) begin
            interrupt_vector <= 4'd1;
        end
    end

endmodule

// File: design/bus_decode_stage.sv
`timescale 1ns/1ps

module bus_decode_stage import bus_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  bus_req_t bus_req,
    input  logic     read_enable,
    input  logic     write_enable,
    output access_t  access
);

    // end of the ram window, exclusive
    localparam addr_t RAM_END = RAM_BASE + addr_t'(RAM_WORDS) * 64'd4;

    logic        strobe;
    target_t     target;
    addr_t       ram_offset;
    logic [31:0] hi_wdata;

    assign strobe = read_enable | write_enable;

    // byte offset into the ram window
    assign ram_offset = bus_req.addr - RAM_BASE;

    // address decode
    // the only place addresses get compared
    always_comb begin
        if (bus_req.addr >= RAM_BASE && bus_req.addr < RAM_END) begin
            target = TGT_RAM;
        end else if (bus_req.addr == KEY_ADDR) begin
            target = TGT_KEY;
        end else if (bus_req.addr == UART_ADDR) begin
            target = TGT_UART;
        end else if (bus_req.addr == MTIME_ADDR) begin
            target = TGT_MTIME;
        end else if (bus_req.addr == MTIMECMP_ADDR) begin
            target = TGT_MTIMECMP;
        end else begin
            // unmapped space completes with zero data
            target = TGT_NONE;
        end
    end

    // upper write half for the second beat of sd
    always_ff @(posedge CLOCK_50) begin
        if (strobe) begin
            hi_wdata <= bus_req.wdata[63:32];
        end
    end

    // beat sequencer
    // strobe at E0 gives beat 0 and a double access adds beat 1 at E1
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            access <= '0;
        end else if (strobe) begin
            access.valid       <= 1'b1;
            access.is_write    <= write_enable;
            access.target      <= target;
            access.word_index  <= ram_offset[33:2];
            access.byte_offset <= bus_req.addr[1:0];
            access.ls_type     <= bus_req.ls_type;
            access.beat        <= 1'b0;
            // single beat unless ld/sd
            access.last        <= (bus_req.ls_type != LS_D);
            access.wdata       <= bus_req.wdata[31:0];
        end else if (access.valid && !access.last) begin
            // second word of a double access
            access.beat       <= 1'b1;
            access.last       <= 1'b1;
            access.word_index <= access.word_index + 32'd1;
            access.wdata      <= hi_wdata;
        end else begin
            access.valid <= 1'b0;
        end
    end

endmodule

// File: design/load_align_stage.sv
`timescale 1ns/1ps

module load_align_stage import bus_pkg::*; (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  access_t access,
    input  resp_t   resp,
    output data_t   read_data,
    output logic    read_done,
    output logic    write_done
);

    data_t shifted;
    data_t ext_data;
    logic  start;
    logic  finish;
    logic  load_beat;

    // beat 0 entering the access stage
    assign start = access.valid && !access.beat;

    // final response of an access
    assign finish = resp.valid && resp.last;

    assign load_beat = resp.valid && !resp.is_write;

    // move the addressed byte down to bit 0
    assign shifted = resp.rdata >> {resp.byte_offset, 3'b000};

    // sign or zero extension by size code
    always_comb begin
        case (resp.ls_type)
            LS_B:    ext_data = {{56{shifted[7]}}, shifted[7:0]};
            LS_H:    ext_data = {{48{shifted[15]}}, shifted[15:0]};
            LS_W:    ext_data = {{32{shifted[31]}}, shifted[31:0]};
            LS_BU:   ext_data = {56'd0, shifted[7:0]};
            LS_HU:   ext_data = {48'd0, shifted[15:0]};
            LS_WU:   ext_data = {32'd0, shifted[31:0]};
            // low half of ld while the upper half comes with beat 1
            LS_D:    ext_data = {32'd0, shifted[31:0]};
            default: ext_data = shifted;
        endcase
    end

    // read data register
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_data <= '0;
        end else if (load_beat) begin
            if (resp.beat) begin
                read_data[63:32] <= resp.rdata[31:0];
            end else begin
                read_data <= ext_data;
            end
        end
    end

    // done levels
    // fall at E1 and rise at E2 for one beat or at E3 for ld/sd
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done  <= 1'b1;
            write_done <= 1'b1;
        end else begin
            if (finish) begin
                if (resp.is_write) begin
                    write_done <= 1'b1;
                end else begin
                    read_done <= 1'b1;
                end
            end
            // a new access takes precedence
            if (start) begin
                if (access.is_write) begin
                    write_done <= 1'b0;
                end else begin
                    read_done <= 1'b0;
                end
            end
        end
    end

endmodule

// File: design/bus_soc_top.sv
`timescale 1ns/1ps

module bus_soc_top import bus_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    // cpu side bus
    input  bus_req_t bus_req,
    input  logic     read_enable,
    input  logic     write_enable,
    output data_t    read_data,
    output logic     read_done,
    output logic     write_done,
    // keyboard
    input  logic [7:0] ascii,
    input  logic     key_pressed,
    // timer
    input  data_t    mtime,
    // interrupt handshake with the cpu
    input  logic     interrupt_ack,
    output logic [3:0] interrupt_vector,
    // uart transmit strobe
    output logic     uart_write,
    output logic [7:0] uart_data
);

    access_t access;
    resp_t   ram_resp;
    resp_t   reg_resp;
    resp_t   resp;

    // stage 1 captures and decodes
    bus_decode_stage #(
        .RAM_WORDS (RAM_WORDS)
    ) u_decode (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .bus_req      (bus_req),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .access       (access)
    );

    // stage 2 for the ram target
    ram_bank #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .access   (access),
        .ram_resp (ram_resp)
    );

    // stage 2 for register targets and unmapped space
    periph_regs u_regs (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .access           (access),
        .ascii            (ascii),
        .key_pressed      (key_pressed),
        .mtime            (mtime),
        .interrupt_ack    (interrupt_ack),
        .reg_resp         (reg_resp),
        .uart_write       (uart_write),
        .uart_data        (uart_data),
        .interrupt_vector (interrupt_vector)
    );

    // only the addressed target answers so the other side is all zero
    assign resp = resp_t'(ram_resp | reg_resp);

    // stage 3 merges, aligns and drives the done levels
    load_align_stage u_align (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .access     (access),
        .resp       (resp),
        .read_data  (read_data),
        .read_done  (read_done),
        .write_done (write_done)
    );

endmodule

// File: testbench/bus_soc_properties.sv
`timescale 1ns/1ps

module bus_soc_properties import bus_pkg::*; (
    input logic     CLOCK_50,
    input logic     KEY0,
    input bus_req_t bus_req,
    input logic     read_enable,
    input logic     write_enable,
    input logic     read_done,
    input logic     write_done,
    input logic     uart_write
);

    logic strobe;
    logic idle;

    assign strobe = read_enable | write_enable;
    assign idle   = read_done & write_done;

    // one access in flight at a time
    never_both_busy: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        read_done || write_done)
        else $error("read_done and write_done both low");

    // uart strobe is a single cycle
    uart_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_write |=> !uart_write)
        else $error("uart_write high for two cycles");

    // single beat access completes at E2
    single_latency: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        strobe && bus_req.ls_type != LS_D |-> ##2 !idle ##1 idle)
        else $error("single beat access did not complete at E2");

    // ld/sd completes at E3
    double_latency: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        strobe && bus_req.ls_type == LS_D |-> ##2 !idle ##1 !idle ##1 idle)
        else $error("double access did not complete at E3");

endmodule

// File: testbench/tb_bus_soc.sv
`timescale 1ns/1ps

module tb_bus_soc import bus_pkg::*; ();

    localparam int    TIMEOUT  = 20;
    localparam addr_t SCRATCH  = RAM_BASE + 64'h10;
    localparam addr_t DWORD    = RAM_BASE + 64'h40;
    localparam addr_t UNMAPPED = 64'h0000_0000_0000_9000;

    logic       CLOCK_50;
    logic       KEY0;
    bus_req_t   bus_req;
    logic       read_enable;
    logic       write_enable;
    logic [7:0] ascii;
    logic       key_pressed;
    data_t      mtime;
    logic       interrupt_ack;
    data_t      read_data;
    logic       read_done;
    logic       write_done;
    logic       uart_write;
    logic [7:0] uart_data;
    logic [3:0] interrupt_vector;

    logic [31:0] lfsr_state;
    // expected contents of the four scratch words
    logic [31:0] ram_model [0:3];
    string       test_name;
    int          err_count;
    int          check_count;
    int          test_errs;
    int          uart_pulses;
    logic [7:0]  uart_last;

    bus_soc_top #(
        .RAM_WORDS (1024)
    ) u_dut (.*);

    bind bus_soc_top bus_soc_properties u_props (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .bus_req      (bus_req),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .read_done    (read_done),
        .write_done   (write_done),
        .uart_write   (uart_write)
    );

    always #4 CLOCK_50 = ~CLOCK_50;

    // uart pulses counted mid cycle
    always @(negedge CLOCK_50) begin
        if (uart_write) begin
            uart_pulses++;
            uart_last = uart_data;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // one lfsr step per bit
    function automatic data_t rand_bits(input int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    // load result from a word, byte offset and size code
    function automatic data_t expect_load(input logic [31:0] w, input int off,
                                          input ls_type_t ls);
        logic [31:0] s;
        s = w >> (8 * off);
        case (ls)
            LS_B:    return {{56{s[7]}}, s[7:0]};
            LS_BU:   return {56'd0, s[7:0]};
            LS_H:    return {{48{s[15]}}, s[15:0]};
            LS_HU:   return {48'd0, s[15:0]};
            LS_W:    return {{32{s[31]}}, s};
            default: return {32'd0, s};
        endcase
    endfunction

    // low bytes of the data land from the offset upward
    task automatic model_store(input int w, input int off, input int nbytes, input data_t v);
        for (int b = 0; b < nbytes; b++) begin
            ram_model[w][8*(off+b) +: 8] = v[8*b +: 8];
        end
    endtask

    task automatic step();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic check_data(input string what, input data_t exp, input data_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            test_errs++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            test_errs++;
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        $display("test %s: %0d errors", test_name, test_errs);
    endtask

    // strobe for one cycle and count edges until both done levels are high
    task automatic bus_access(input logic wr, input addr_t addr, input ls_type_t ls,
                              input data_t wd, output data_t rd, output int edges);
        int n;
        n = 0;
        bus_req.addr    = addr;
        bus_req.ls_type = ls;
        bus_req.wdata   = wd;
        read_enable     = !wr;
        write_enable    = wr;
        step();
        read_enable  = 1'b0;
        write_enable = 1'b0;
        do begin
            step();
            n++;
            // only the done level of this access kind drops at E1
            if (n == 1) begin
                check_bit("busy done", 1'b0, wr ? write_done : read_done);
                check_bit("other done", 1'b1, wr ? read_done : write_done);
            end
        end while (!(read_done && write_done) && n < TIMEOUT);
        if (!(read_done && write_done)) begin
            err_count++;
            test_errs++;
            $display("%s: timeout, done never came back high after the access", test_name);
        end
        rd    = read_data;
        edges = n;
    endtask

    task automatic store(input addr_t addr, input ls_type_t ls, input data_t wd);
        data_t rd;
        int    n;
        bus_access(1'b1, addr, ls, wd, rd, n);
    endtask

    task automatic load_check(input string what, input addr_t addr, input ls_type_t ls,
                              input data_t exp);
        data_t rd;
        int    n;
        bus_access(1'b0, addr, ls, '0, rd, n);
        check_data(what, exp, rd);
    endtask

    task automatic wait_vector(input logic [3:0] exp);
        int n;
        n = 0;
        while (interrupt_vector !== exp && n < TIMEOUT) begin
            step();
            n++;
        end
        check_data("vector", data_t'(exp), data_t'(interrupt_vector));
    endtask

    task automatic reset_values();
        begin_test("reset");
        check_bit("read_done", 1'b1, read_done);
        check_bit("write_done", 1'b1, write_done);
        check_bit("uart_write", 1'b0, uart_write);
        check_data("vector", '0, data_t'(interrupt_vector));
        check_data("read_data", '0, read_data);
        end_test();
    endtask

    task automatic sized_loads();
        data_t v;
        addr_t a;
        begin_test("sized");
        for (int w = 0; w < 4; w++) begin
            v = rand_bits(32);
            ram_model[w] = v[31:0];
            store(SCRATCH + addr_t'(4 * w), LS_W, v);
        end
        // overwrite single lanes
        v = rand_bits(16);
        store(SCRATCH + 64'd1, LS_B, v);
        model_store(0, 1, 1, v);
        v = rand_bits(16);
        store(SCRATCH + 64'd7, LS_B, v);
        model_store(1, 3, 1, v);
        v = rand_bits(16);
        store(SCRATCH + 64'd10, LS_H, v);
        model_store(2, 2, 2, v);
        v = rand_bits(16);
        store(SCRATCH + 64'd12, LS_H, v);
        model_store(3, 0, 2, v);
        for (int w = 0; w < 4; w++) begin
            for (int o = 0; o < 4; o++) begin
                a = SCRATCH + addr_t'(4 * w + o);
                load_check("lb", a, LS_B, expect_load(ram_model[w], o, LS_B));
                load_check("lbu", a, LS_BU, expect_load(ram_model[w], o, LS_BU));
                if (o % 2 == 0) begin
                    load_check("lh", a, LS_H, expect_load(ram_model[w], o, LS_H));
                    load_check("lhu", a, LS_HU, expect_load(ram_model[w], o, LS_HU));
                end
                if (o == 0) begin
                    load_check("lw", a, LS_W, expect_load(ram_model[w], o, LS_W));
                    load_check("lwu", a, LS_WU, expect_load(ram_model[w], o, LS_WU));
                end
            end
        end
        end_test();
    endtask

    task automatic double_word();
        data_t v;
        data_t rd;
        int    n;
        begin_test("double");
        v = rand_bits(64);
        bus_access(1'b1, DWORD, LS_D, v, rd, n);
        check_data("sd edges", 64'd3, data_t'(n));
        bus_access(1'b0, DWORD, LS_D, '0, rd, n);
        check_data("ld data", v, rd);
        check_data("ld edges", 64'd3, data_t'(n));
        // low word sits at the lower address
        bus_access(1'b0, DWORD, LS_W, '0, rd, n);
        check_data("lw low", {{32{v[31]}}, v[31:0]}, rd);
        check_data("lw edges", 64'd2, data_t'(n));
        load_check("lw high", DWORD + 64'd4, LS_W, {{32{v[63]}}, v[63:32]});
        end_test();
    endtask

    task automatic register_reads();
        data_t v;
        begin_test("regs");
        v = rand_bits(64);
        store(MTIMECMP_ADDR, LS_D, v);
        load_check("mtimecmp", MTIMECMP_ADDR, LS_D, v);
        mtime = rand_bits(64);
        load_check("mtime", MTIME_ADDR, LS_D, mtime);
        // nonzero ascii while the key is up
        ascii = 8'(rand_bits(7)) | 8'h40;
        load_check("key", KEY_ADDR, LS_BU, {56'd0, ascii});
        load_check("unmapped", UNMAPPED, LS_D, '0);
        end_test();
    endtask

    task automatic uart_pulse();
        data_t v;
        begin_test("uart");
        uart_pulses = 0;
        v = rand_bits(32);
        store(UART_ADDR, LS_W, v);
        step();
        step();
        check_data("pulses", 64'd1, data_t'(uart_pulses));
        check_data("byte", {56'd0, v[7:0]}, {56'd0, uart_last});
        end_test();
    endtask

    task automatic keyboard_irq();
        begin_test("irq");
        // key with zero ascii leaves the vector alone
        ascii       = 8'd0;
        key_pressed = 1'b1;
        step();
        step();
        check_data("zero ascii", '0, data_t'(interrupt_vector));
        ascii = 8'(rand_bits(7)) | 8'h01;
        wait_vector(4'd1);
        key_pressed   = 1'b0;
        interrupt_ack = 1'b1;
        wait_vector(4'd0);
        interrupt_ack = 1'b0;
        end_test();
    endtask

    initial begin
        CLOCK_50      = 1'b0;
        KEY0          = 1'b0;
        bus_req       = '0;
        read_enable   = 1'b0;
        write_enable  = 1'b0;
        ascii         = 8'd0;
        key_pressed   = 1'b0;
        mtime         = '0;
        interrupt_ack = 1'b0;
        lfsr_state    = 32'hd802_d17f;
        err_count     = 0;
        check_count   = 0;
        uart_pulses   = 0;
        uart_last     = 8'd0;
        repeat (4) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        reset_values();
        sized_loads();
        double_word();
        register_reads();
        uart_pulse();
        keyboard_irq();
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
design/bus_pkg.sv
design/ram_bank.sv
design/periph_regs.sv
design/bus_decode_stage.sv
design/load_align_stage.sv
design/bus_soc_top.sv
testbench/bus_soc_properties.sv
testbench/tb_bus_soc.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_bus_soc \
    -f verilog.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation run ok" \
    || { echo "simulation run not ok"; exit 1; }
